// File: include/mbus_consts.svh
`ifndef MBUS_CONSTS_SVH
`define MBUS_CONSTS_SVH

// Frame layout.
`define MBUS_ADDR_WIDTH      8
`define MBUS_DATA_WIDTH      32
`define MBUS_FRAME_BITS      40

// clk_ext cycles per half bus clock period.
`define MBUS_CLK_DIV         4

// Frames held by the receive FIFO.
`define MBUS_FIFO_DEPTH      4

// Accepted by every node.
`define MBUS_BROADCAST_ADDR  8'h0f

`endif

// File: src/mbus_pkg.sv
`include "mbus_consts.svh"

package mbus_pkg;

   typedef logic [`MBUS_ADDR_WIDTH-1:0] mbus_addr_t;
   typedef logic [`MBUS_DATA_WIDTH-1:0] mbus_data_t;

   // Transmitter framing states.
   typedef enum logic [2:0] {
      TX_IDLE,
      TX_START,
      TX_BIT_LOW,
      TX_BIT_HIGH,
      TX_STOP
   } tx_state_t;

   // Receiver deframing states.
   typedef enum logic [1:0] {
      RX_IDLE,
      RX_SHIFT,
      RX_DONE
   } rx_state_t;

endpackage

// File: src/mbus_tx_ctrl.sv
`timescale 1ns/1ps
`include "mbus_consts.svh"

module mbus_tx_ctrl
   import mbus_pkg::*;
(
   input  logic       clk_ext,
   input  logic       rst,
   input  mbus_addr_t tx_addr,
   input  mbus_data_t tx_data,
   input  logic       tx_req,
   output logic       tx_ack,
   output logic       tx_succ,
   input  logic       bus_busy,
   input  logic       clkin,
   input  logic       din,
   output logic       clkout,
   output logic       dout
);

   localparam int DIV_W = $clog2(3 * `MBUS_CLK_DIV);
   localparam int CNT_W = $clog2(`MBUS_FRAME_BITS);
   localparam logic [DIV_W-1:0] HALF_END  = DIV_W'(`MBUS_CLK_DIV - 1);
   localparam logic [DIV_W-1:0] STOP_RISE = DIV_W'(2 * `MBUS_CLK_DIV - 1);
   localparam logic [DIV_W-1:0] STOP_END  = DIV_W'(3 * `MBUS_CLK_DIV - 1);
   localparam logic [CNT_W-1:0] LAST_BIT  = CNT_W'(`MBUS_FRAME_BITS - 1);

   tx_state_t                   state;
   logic [DIV_W-1:0]            div;
   logic [CNT_W-1:0]            bit_cnt;
   logic [`MBUS_FRAME_BITS-1:0] shift_q;
   logic                        accept;
   logic                        half_end;
   logic                        next_bit;

   assign accept   = (state == TX_IDLE) && tx_req && !bus_busy;
   assign half_end = (div == HALF_END);
   assign next_bit = (state == TX_BIT_HIGH) && half_end && (bit_cnt != LAST_BIT);

   // Address in the top byte, sent MSB first.
   always_ff @(posedge clk_ext) begin
      if (accept) begin
         shift_q <= {tx_addr, tx_data};
      end else if (next_bit) begin
         shift_q <= {shift_q[`MBUS_FRAME_BITS-2:0], 1'b0};
      end
   end

   always_ff @(posedge clk_ext) begin
      if (rst) begin
         state   <= TX_IDLE;
         div     <= '0;
         bit_cnt <= '0;
         tx_ack  <= 1'b0;
         tx_succ <= 1'b0;
         clkout  <= 1'b1;
         dout    <= 1'b1;
      end else begin
         tx_ack  <= 1'b0;
         tx_succ <= 1'b0;
         div     <= div + 1'b1;
         case (state)
            TX_IDLE: begin
               // Ring forwarding.
               clkout <= clkin;
               dout   <= din;
               div    <= '0;
               if (accept) begin
                  tx_ack  <= 1'b1;
                  bit_cnt <= '0;
                  clkout  <= 1'b1;
                  dout    <= 1'b0;
                  state   <= TX_START;
               end
            end
            TX_START: begin
               if (half_end) begin
                  div    <= '0;
                  clkout <= 1'b0;
                  dout   <= shift_q[`MBUS_FRAME_BITS-1];
                  state  <= TX_BIT_LOW;
               end
            end
            TX_BIT_LOW: begin
               if (half_end) begin
                  div    <= '0;
                  clkout <= 1'b1;
                  state  <= TX_BIT_HIGH;
               end
            end
            TX_BIT_HIGH: begin
               if (half_end) begin
                  div    <= '0;
                  clkout <= 1'b0;
                  if (bit_cnt == LAST_BIT) begin
                     dout  <= 1'b0;
                     state <= TX_STOP;
                  end else begin
                     dout    <= shift_q[`MBUS_FRAME_BITS-2];
                     bit_cnt <= bit_cnt + 1'b1;
                     state   <= TX_BIT_LOW;
                  end
               end
            end
            TX_STOP: begin
               // Clock rises with data low, then data rises.
               if (div == HALF_END) begin
                  clkout <= 1'b1;
               end
               if (div == STOP_RISE) begin
                  dout <= 1'b1;
               end
               if (div == STOP_END) begin
                  tx_succ <= 1'b1;
                  state   <= TX_IDLE;
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   a_ack_from_idle: assert property (@(posedge clk_ext) disable iff (rst)
      tx_ack |-> ($past(state) == TX_IDLE) && (state == TX_START));

endmodule

// File: src/mbus_rx_ctrl.sv
`timescale 1ns/1ps
`include "mbus_consts.svh"

module mbus_rx_ctrl
   import mbus_pkg::*;
#(
   parameter mbus_addr_t ADDRESS = 8'h2a
) (
   input  logic       clk_ext,
   input  logic       rst,
   input  logic       clkin,
   input  logic       din,
   output logic       bus_busy,
   output logic       frm_wr,
   output mbus_addr_t frm_addr,
   output mbus_data_t frm_data,
   output logic       frm_bcast,
   input  logic       fifo_full,
   output logic       rx_fail
);

   // The stop condition adds one rising edge after the last data bit.
   localparam int SHIFT_W = `MBUS_FRAME_BITS + 1;
   localparam int CNT_W   = $clog2(`MBUS_FRAME_BITS + 3);
   localparam logic [CNT_W-1:0] GOOD_CNT = CNT_W'(`MBUS_FRAME_BITS + 1);

   rx_state_t          state;
   logic               clk_s1;
   logic               clk_s2;
   logic               clk_d;
   logic               din_s1;
   logic               din_s2;
   logic               din_d;
   logic               clk_rise;
   logic               start_det;
   logic               stop_det;
   logic [CNT_W-1:0]   rise_cnt;
   logic [SHIFT_W-1:0] shift_q;
   logic               good_len;
   logic               addr_match;

   always_ff @(posedge clk_ext) begin
      if (rst) begin
         clk_s1 <= 1'b1;
         clk_s2 <= 1'b1;
         clk_d  <= 1'b1;
         din_s1 <= 1'b1;
         din_s2 <= 1'b1;
         din_d  <= 1'b1;
      end else begin
         clk_s1 <= clkin;
         clk_s2 <= clk_s1;
         clk_d  <= clk_s2;
         din_s1 <= din;
         din_s2 <= din_s1;
         din_d  <= din_s2;
      end
   end

   assign clk_rise  = clk_s2 && !clk_d;
   assign start_det = clk_s2 && clk_d && !din_s2 && din_d;
   assign stop_det  = clk_s2 && clk_d && din_s2 && !din_d;

   // Bit 0 holds the stop's own clock edge.
   assign frm_addr   = shift_q[`MBUS_FRAME_BITS -: `MBUS_ADDR_WIDTH];
   assign frm_data   = shift_q[`MBUS_DATA_WIDTH:1];
   assign frm_bcast  = (frm_addr == `MBUS_BROADCAST_ADDR);
   assign addr_match = (frm_addr == ADDRESS);
   assign good_len   = (rise_cnt == GOOD_CNT);

   always_ff @(posedge clk_ext) begin
      if ((state == RX_SHIFT) && clk_rise) begin
         shift_q <= {shift_q[SHIFT_W-2:0], din_s2};
      end
   end

   always_ff @(posedge clk_ext) begin
      if (rst) begin
         state    <= RX_IDLE;
         rise_cnt <= '0;
         bus_busy <= 1'b0;
         frm_wr   <= 1'b0;
         rx_fail  <= 1'b0;
      end else begin
         frm_wr  <= 1'b0;
         rx_fail <= 1'b0;
         if (start_det) begin
            bus_busy <= 1'b1;
         end else if (stop_det) begin
            bus_busy <= 1'b0;
         end
         case (state)
            RX_IDLE: begin
               if (start_det) begin
                  rise_cnt <= '0;
                  state    <= RX_SHIFT;
               end
            end
            RX_SHIFT: begin
               if (stop_det) begin
                  state <= RX_DONE;
               end else if (start_det) begin
                  rise_cnt <= '0;
               end else if (clk_rise && (rise_cnt <= GOOD_CNT)) begin
                  rise_cnt <= rise_cnt + 1'b1;
               end
            end
            RX_DONE: begin
               state <= RX_IDLE;
               if (!good_len) begin
                  rx_fail <= 1'b1;
               end else if (addr_match || frm_bcast) begin
                  if (fifo_full) begin
                     rx_fail <= 1'b1;
                  end else begin
                     frm_wr <= 1'b1;
                  end
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   a_wr_or_fail: assert property (@(posedge clk_ext) disable iff (rst)
      !(frm_wr && rx_fail));

endmodule

// File: src/mbus_rx_fifo.sv
`timescale 1ns/1ps
`include "mbus_consts.svh"

module mbus_rx_fifo
   import mbus_pkg::*;
(
   input  logic       clk_ext,
   input  logic       rst,
   input  logic       frm_wr,
   input  mbus_addr_t frm_addr,
   input  mbus_data_t frm_data,
   input  logic       frm_bcast,
   input  logic       fifo_rd,
   output mbus_addr_t head_addr,
   output mbus_data_t head_data,
   output logic       head_bcast,
   output logic       fifo_empty,
   output logic       fifo_full,
   output logic       fifo_more
);

   localparam int DEPTH = `MBUS_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

   mbus_addr_t       addr_mem [DEPTH];
   mbus_data_t       data_mem [DEPTH];
   logic             bcast_mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_wr;
   logic             do_rd;

   assign do_wr      = frm_wr && !fifo_full;
   assign do_rd      = fifo_rd && !fifo_empty;
   assign fifo_empty = (count == '0);
   assign fifo_full  = (count == CNT_W'(DEPTH));
   assign fifo_more  = (count > CNT_W'(1));
   assign head_addr  = addr_mem[rd_ptr];
   assign head_data  = data_mem[rd_ptr];
   assign head_bcast = bcast_mem[rd_ptr];

   always_ff @(posedge clk_ext) begin
      if (do_wr) begin
         addr_mem[wr_ptr]  <= frm_addr;
         data_mem[wr_ptr]  <= frm_data;
         bcast_mem[wr_ptr] <= frm_bcast;
      end
   end

   always_ff @(posedge clk_ext) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   a_no_wr_full: assert property (@(posedge clk_ext) disable iff (rst)
      frm_wr |-> !fifo_full);

   a_no_rd_empty: assert property (@(posedge clk_ext) disable iff (rst)
      fifo_rd |-> !fifo_empty);

endmodule

// File: src/mbus_rx_port.sv
`timescale 1ns/1ps
`include "mbus_consts.svh"

module mbus_rx_port
   import mbus_pkg::*;
(
   input  logic       clk_ext,
   input  logic       rst,
   input  mbus_addr_t head_addr,
   input  mbus_data_t head_data,
   input  logic       head_bcast,
   input  logic       fifo_empty,
   input  logic       fifo_more,
   output logic       fifo_rd,
   output mbus_addr_t rx_addr,
   output mbus_data_t rx_data,
   output logic       rx_broadcast,
   output logic       rx_req,
   input  logic       rx_ack,
   output logic       rx_pend
);

   // Load and pop in the same cycle.
   assign fifo_rd = !rx_req && !fifo_empty;

   always_ff @(posedge clk_ext) begin
      if (fifo_rd) begin
         rx_addr      <= head_addr;
         rx_data      <= head_data;
         rx_broadcast <= head_bcast;
      end
   end

   always_ff @(posedge clk_ext) begin
      if (rst) begin
         rx_req  <= 1'b0;
         rx_pend <= 1'b0;
      end else if (fifo_rd) begin
         rx_req  <= 1'b1;
         // Head leaves now, so only a second entry counts.
         rx_pend <= fifo_more;
      end else if (rx_req && rx_ack) begin
         rx_req  <= 1'b0;
         rx_pend <= 1'b0;
      end else if (rx_req) begin
         rx_pend <= !fifo_empty;
      end
   end

   a_rx_stable: assert property (@(posedge clk_ext) disable iff (rst)
      (rx_req && $past(rx_req)) |->
         ($stable(rx_addr) && $stable(rx_data) && $stable(rx_broadcast)));

endmodule

// File: src/mbus_node.sv
`timescale 1ns/1ps
`include "mbus_consts.svh"

module mbus_node
   import mbus_pkg::*;
#(
   parameter mbus_addr_t ADDRESS = 8'h2a
) (
   input  logic       clk_ext,
   input  logic       rst,
   input  logic       clkin,
   input  logic       din,
   output logic       clkout,
   output logic       dout,
   input  mbus_addr_t tx_addr,
   input  mbus_data_t tx_data,
   input  logic       tx_req,
   output logic       tx_ack,
   output logic       tx_succ,
   output mbus_addr_t rx_addr,
   output mbus_data_t rx_data,
   output logic       rx_req,
   input  logic       rx_ack,
   output logic       rx_broadcast,
   output logic       rx_pend,
   output logic       rx_fail
);

   logic       bus_busy;
   logic       frm_wr;
   mbus_addr_t frm_addr;
   mbus_data_t frm_data;
   logic       frm_bcast;
   logic       fifo_rd;
   logic       fifo_empty;
   logic       fifo_full;
   logic       fifo_more;
   mbus_addr_t head_addr;
   mbus_data_t head_data;
   logic       head_bcast;

   mbus_tx_ctrl tx0 (
      .clk_ext  (clk_ext),
      .rst      (rst),
      .tx_addr  (tx_addr),
      .tx_data  (tx_data),
      .tx_req   (tx_req),
      .tx_ack   (tx_ack),
      .tx_succ  (tx_succ),
      .bus_busy (bus_busy),
      .clkin    (clkin),
      .din      (din),
      .clkout   (clkout),
      .dout     (dout)
   );

   mbus_rx_ctrl #(.ADDRESS(ADDRESS)) rx0 (
      .clk_ext   (clk_ext),
      .rst       (rst),
      .clkin     (clkin),
      .din       (din),
      .bus_busy  (bus_busy),
      .frm_wr    (frm_wr),
      .frm_addr  (frm_addr),
      .frm_data  (frm_data),
      .frm_bcast (frm_bcast),
      .fifo_full (fifo_full),
      .rx_fail   (rx_fail)
   );

   mbus_rx_fifo fifo0 (
      .clk_ext    (clk_ext),
      .rst        (rst),
      .frm_wr     (frm_wr),
      .frm_addr   (frm_addr),
      .frm_data   (frm_data),
      .frm_bcast  (frm_bcast),
      .fifo_rd    (fifo_rd),
      .head_addr  (head_addr),
      .head_data  (head_data),
      .head_bcast (head_bcast),
      .fifo_empty (fifo_empty),
      .fifo_full  (fifo_full),
      .fifo_more  (fifo_more)
   );

   mbus_rx_port port0 (
      .clk_ext      (clk_ext),
      .rst          (rst),
      .head_addr    (head_addr),
      .head_data    (head_data),
      .head_bcast   (head_bcast),
      .fifo_empty   (fifo_empty),
      .fifo_more    (fifo_more),
      .fifo_rd      (fifo_rd),
      .rx_addr      (rx_addr),
      .rx_data      (rx_data),
      .rx_broadcast (rx_broadcast),
      .rx_req       (rx_req),
      .rx_ack       (rx_ack),
      .rx_pend      (rx_pend)
   );

endmodule

// File: bench/mbus_node_tasks.svh
`ifndef MBUS_NODE_TASKS_SVH
`define MBUS_NODE_TASKS_SVH

// Selectors for the timed waits.
localparam int SIG_TX_ACK  = 0;
localparam int SIG_TX_SUCC = 1;
localparam int SIG_RX_REQ  = 2;
localparam int SIG_RX_FAIL = 3;
localparam int SIG_RX_PEND = 4;
localparam int SIG_FWD     = 5;

function automatic logic signal_high(input int sel);
   case (sel)
      SIG_TX_ACK:  signal_high = tx_ack;
      SIG_TX_SUCC: signal_high = tx_succ;
      SIG_RX_REQ:  signal_high = rx_req;
      SIG_RX_FAIL: signal_high = rx_fail;
      SIG_RX_PEND: signal_high = rx_pend;
      SIG_FWD:     signal_high = (clkout === ext_clk) && (dout === ext_din);
      default:     signal_high = 1'b0;
   endcase
endfunction

task check(input string name, input logic [63:0] got, input logic [63:0] exp);
   if (got !== exp) begin
      $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
      $display("sim failed");
      $fatal(1);
   end
endtask

// Outputs are sampled on the falling edge.
task wait_until(input int sel, input string what, input int limit);
   int n;
   n = 0;
   @(negedge clk_ext);
   while (!signal_high(sel)) begin
      if (n == limit) begin
         $display("Timed out waiting for %s.", what);
         $display("sim failed");
         $fatal(1);
      end else begin
         n = n + 1;
         @(negedge clk_ext);
      end
   end
endtask

task drive_bus(input logic c, input logic d, input int cycles);
   @(posedge clk_ext);
   ext_clk <= c;
   ext_din <= d;
   repeat (cycles - 1) @(posedge clk_ext);
endtask

// Returns right after data rises for the stop.
task send_bus_frame(input mbus_addr_t addr, input mbus_data_t data, input int nbits);
   logic [`MBUS_FRAME_BITS-1:0] frame;
   int i;
   frame = {addr, data};
   drive_bus(1'b1, 1'b1, 2 * HALF);
   drive_bus(1'b1, 1'b0, HALF);
   for (i = 0; i < nbits; i++) begin
      drive_bus(1'b0, frame[`MBUS_FRAME_BITS-1-i], HALF);
      drive_bus(1'b1, frame[`MBUS_FRAME_BITS-1-i], HALF);
   end
   drive_bus(1'b0, 1'b0, HALF);
   drive_bus(1'b1, 1'b0, HALF);
   drive_bus(1'b1, 1'b1, 1);
endtask

task host_send(input mbus_addr_t addr, input mbus_data_t data);
   @(posedge clk_ext);
   tx_addr <= addr;
   tx_data <= data;
   tx_req  <= 1'b1;
   wait_until(SIG_TX_ACK, "tx_ack", 100);
   @(posedge clk_ext);
   tx_req <= 1'b0;
   wait_until(SIG_TX_SUCC, "tx_succ", 2000);
endtask

task host_receive(input mbus_addr_t addr, input mbus_data_t data, input logic bcast,
                  input logic pend);
   wait_until(SIG_RX_REQ, "rx_req", 200);
   check("rx_addr", rx_addr, addr);
   check("rx_data", rx_data, data);
   check("rx_broadcast", rx_broadcast, bcast);
   check("rx_pend", rx_pend, pend);
   @(posedge clk_ext);
   rx_ack <= 1'b1;
   @(posedge clk_ext);
   rx_ack <= 1'b0;
   @(negedge clk_ext);
   check("rx_req", rx_req, 1'b0);
endtask

// Neither rx_fail nor, optionally, rx_req may rise.
task expect_quiet(input int cycles, input logic req_too);
   repeat (cycles) begin
      @(negedge clk_ext);
      check("rx_fail", rx_fail, 1'b0);
      if (req_too) begin
         check("rx_req", rx_req, 1'b0);
      end
   end
endtask

`endif

// File: bench/mbus_node_tb.sv
`timescale 1ns/1ps
`include "mbus_consts.svh"

module mbus_node_tb
   import mbus_pkg::*;
();

   localparam int HALF = `MBUS_CLK_DIV;
   // The port register holds one frame beyond the FIFO.
   localparam int CAP  = `MBUS_FIFO_DEPTH + 1;

   logic       clk_ext;
   logic       rst;
   logic       loopback;
   logic       ext_clk;
   logic       ext_din;
   logic       clkin;
   logic       din;
   logic       clkout;
   logic       dout;
   mbus_addr_t tx_addr;
   mbus_data_t tx_data;
   logic       tx_req;
   logic       tx_ack;
   logic       tx_succ;
   mbus_addr_t rx_addr;
   mbus_data_t rx_data;
   logic       rx_req;
   logic       rx_ack;
   logic       rx_broadcast;
   logic       rx_pend;
   logic       rx_fail;
   integer     seed;
   mbus_data_t words [CAP+1];

   `include "mbus_node_tasks.svh"

   initial begin
      clk_ext = 1'b0;
      forever #4 clk_ext = ~clk_ext;
   end

   // Ring input comes from our own outputs or from the bench.
   assign clkin = loopback ? clkout : ext_clk;
   assign din   = loopback ? dout : ext_din;

   mbus_node #(.ADDRESS(8'h2a)) mbus_node_i (
      .clk_ext      (clk_ext),
      .rst          (rst),
      .clkin        (clkin),
      .din          (din),
      .clkout       (clkout),
      .dout         (dout),
      .tx_addr      (tx_addr),
      .tx_data      (tx_data),
      .tx_req       (tx_req),
      .tx_ack       (tx_ack),
      .tx_succ      (tx_succ),
      .rx_addr      (rx_addr),
      .rx_data      (rx_data),
      .rx_req       (rx_req),
      .rx_ack       (rx_ack),
      .rx_broadcast (rx_broadcast),
      .rx_pend      (rx_pend),
      .rx_fail      (rx_fail)
   );

   task reset_values;
      @(negedge clk_ext);
      check("clkout", clkout, 1'b1);
      check("dout", dout, 1'b1);
      check("tx_ack", tx_ack, 1'b0);
      check("tx_succ", tx_succ, 1'b0);
      check("rx_req", rx_req, 1'b0);
      check("rx_fail", rx_fail, 1'b0);
      check("rx_pend", rx_pend, 1'b0);
   endtask

   task loopback_unicast;
      mbus_data_t d;
      d = $random(seed);
      host_send(8'h2a, d);
      host_receive(8'h2a, d, 1'b0, 1'b0);
   endtask

   task ring_forwarding;
      logic [11:0] steps;
      int i;
      // Data changes only while the clock is low, so no start or stop.
      steps = 12'b01_00_10_00_01_11;
      @(posedge clk_ext);
      loopback <= 1'b0;
      for (i = 5; i >= 0; i--) begin
         drive_bus(steps[2*i+1], steps[2*i], 1);
         wait_until(SIG_FWD, "clkout and dout to follow the ring", 10);
      end
   endtask

   task external_frames;
      mbus_data_t d0;
      mbus_data_t d1;
      d0 = $random(seed);
      d1 = $random(seed);
      send_bus_frame(`MBUS_BROADCAST_ADDR, d0, `MBUS_FRAME_BITS);
      host_receive(`MBUS_BROADCAST_ADDR, d0, 1'b1, 1'b0);
      send_bus_frame(8'h33, d1, `MBUS_FRAME_BITS);
      expect_quiet(200, 1'b1);
   endtask

   task short_frame_fail;
      mbus_data_t d;
      d = $random(seed);
      send_bus_frame(8'h2a, d, 20);
      wait_until(SIG_RX_FAIL, "rx_fail after a short frame", 100);
      expect_quiet(100, 1'b1);
   endtask

   task fill_and_drain;
      int k;
      for (k = 0; k <= CAP; k++) begin
         words[k] = $random(seed);
         send_bus_frame(8'h2a, words[k], `MBUS_FRAME_BITS);
         if (k == CAP) begin
            wait_until(SIG_RX_FAIL, "rx_fail for a frame with the FIFO full", 100);
         end else begin
            expect_quiet(12, 1'b0);
            if (k > 0) begin
               wait_until(SIG_RX_PEND, "rx_pend with frames waiting", 50);
            end
         end
      end
      for (k = 0; k < CAP; k++) begin
         host_receive(8'h2a, words[k], 1'b0, k < CAP - 1);
      end
      expect_quiet(100, 1'b1);
   endtask

   initial begin
      seed     = 32'hafb52b78;
      rst      = 1'b1;
      loopback = 1'b1;
      ext_clk  = 1'b1;
      ext_din  = 1'b1;
      tx_req   = 1'b0;
      tx_addr  = '0;
      tx_data  = '0;
      rx_ack   = 1'b0;
      repeat (4) @(posedge clk_ext);
      rst <= 1'b0;
      reset_values;
      loopback_unicast;
      ring_forwarding;
      external_frames;
      short_frame_fail;
      fill_and_drain;
      $display("sim passed");
      $finish;
   end

endmodule

// File: verilog.f
+incdir+include
+incdir+bench
src/mbus_pkg.sv
src/mbus_tx_ctrl.sv
src/mbus_rx_ctrl.sv
src/mbus_rx_fifo.sv
src/mbus_rx_port.sv
src/mbus_node.sv
bench/mbus_node_tb.sv
